//--- hdl/hyper_pkg.sv
// Shared definitions for the HyperBus front end
// Bus widths and their vector types
// Per-channel configuration register offsets
// Transaction struct carried from channel to PHY

`default_nettype none

package hyper_pkg;

   parameter int HYPER_AWIDTH = 32;
   parameter int TRANS_SIZE   = 16;
   parameter int DATA_WIDTH   = 32;
   parameter int CFG_AWIDTH   = 5;

   typedef logic [HYPER_AWIDTH-1:0] hyper_addr_t;
   typedef logic [TRANS_SIZE-1:0]   burst_t;
   typedef logic [DATA_WIDTH-1:0]   data_t;

   // Register map of one channel
   parameter logic [CFG_AWIDTH-1:0] REG_ADDR   = 5'd0;
   parameter logic [CFG_AWIDTH-1:0] REG_SIZE   = 5'd1;
   // Bit 0 is rw, 1 for a read; writing here queues the command
   parameter logic [CFG_AWIDTH-1:0] REG_CTRL   = 5'd2;
   parameter logic [CFG_AWIDTH-1:0] REG_STATUS = 5'd3;

   typedef struct packed {
      hyper_addr_t address;
      burst_t      burst;
      logic        read;
   } hyper_trans_t;

endpackage

`default_nettype wire

//--- hdl/hyper_trans_if.sv
// Transaction handshake between arbiter, FIFO and controller
// One transaction with its channel id, valid/ready pair

`default_nettype none

interface hyper_trans_if #(
   parameter int NB_CH = 4
);
   import hyper_pkg::*;

   localparam int ID_W = (NB_CH > 1) ? $clog2(NB_CH) : 1;

   logic            valid;
   logic            ready;
   hyper_trans_t    trans;
   logic [ID_W-1:0] id;

   // Source holds valid, trans and id until ready
   modport src (
      output valid,
      output trans,
      output id,
      input  ready
   );

   modport dst (
      input  valid,
      input  trans,
      input  id,
      output ready
   );

endinterface

`default_nettype wire

//--- hdl/hyper_cmd_queue.sv
// Command registers of one channel
// Address, size and rw registers on the configuration bus
// Pending flag that offers one queued command to the arbiter

`default_nettype none

module hyper_cmd_queue (
   input  logic                            sys_clk_i,
   input  logic                            rst_n_i,

   input  hyper_pkg::data_t                cfg_data_i,
   input  logic [hyper_pkg::CFG_AWIDTH-1:0] cfg_addr_i,
   input  logic                            cfg_valid_i,
   input  logic                            cfg_rwn_i,
   output hyper_pkg::data_t                cfg_data_o,
   output logic                            cfg_ready_o,

   output logic                            cmd_valid_o,
   output hyper_pkg::hyper_trans_t         cmd_o,
   input  logic                            cmd_ready_i
);
   import hyper_pkg::*;

   hyper_addr_t addr_q;
   burst_t      size_q;
   logic        rw_q;
   logic        pending_q;
   logic        cfg_wr;

   assign cfg_ready_o = 1'b1;

   // Registers frozen while a command is queued
   assign cfg_wr = cfg_valid_i && !cfg_rwn_i && !pending_q;

   always_ff @(posedge sys_clk_i) begin
      if (!rst_n_i) begin
         addr_q    <= '0;
         size_q    <= '0;
         rw_q      <= 1'b0;
         pending_q <= 1'b0;
      end else begin
         if (cfg_wr) begin
            case (cfg_addr_i)
               REG_ADDR: addr_q <= cfg_data_i;
               REG_SIZE: size_q <= cfg_data_i[TRANS_SIZE-1:0];
               REG_CTRL: begin
                  rw_q      <= cfg_data_i[0];
                  pending_q <= 1'b1;
               end
               default: ;
            endcase
         end
         if (pending_q && cmd_ready_i) begin
            pending_q <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////
   // Register readback
   always_comb begin
      case (cfg_addr_i)
         REG_ADDR:   cfg_data_o = addr_q;
         REG_SIZE:   cfg_data_o = data_t'(size_q);
         REG_CTRL:   cfg_data_o = data_t'(rw_q);
         REG_STATUS: cfg_data_o = data_t'(pending_q);
         default:    cfg_data_o = '0;
      endcase
   end

   assign cmd_valid_o   = pending_q;
   assign cmd_o.address = addr_q;
   assign cmd_o.burst   = size_q;
   assign cmd_o.read    = rw_q;

endmodule

`default_nettype wire

//--- hdl/hyper_rr_arb.sv
// Round-robin arbiter over the channel commands
// Rotating priority pointer, selection locked while stalled

`default_nettype none

module hyper_rr_arb #(
   parameter int NB_CH = 4
) (
   input  logic                                sys_clk_i,
   input  logic                                rst_n_i,
   input  logic [NB_CH-1:0]                    req_i,
   input  hyper_pkg::hyper_trans_t [NB_CH-1:0] cmd_i,
   output logic [NB_CH-1:0]                    gnt_o,
   hyper_trans_if.src                          out_if
);

   localparam int ID_W = (NB_CH > 1) ? $clog2(NB_CH) : 1;

   logic [ID_W-1:0] ptr_q;
   logic [ID_W-1:0] sel;
   logic [ID_W-1:0] lock_id_q;
   logic            lock_q;
   logic            found;
   logic            accept;

   // First requester at or after the pointer
   always_comb begin
      found = 1'b0;
      sel   = lock_id_q;
      if (lock_q) begin
         found = 1'b1;
      end else begin
         for (int i = 0; i < NB_CH; i++) begin
            if (!found && req_i[(int'(ptr_q) + i) % NB_CH]) begin
               found = 1'b1;
               sel   = ID_W'((int'(ptr_q) + i) % NB_CH);
            end
         end
      end
   end

   assign out_if.valid = found;
   assign out_if.trans = cmd_i[sel];
   assign out_if.id    = sel;
   assign accept       = found && out_if.ready;

   always_comb begin
      gnt_o = '0;
      if (accept) begin
         gnt_o[sel] = 1'b1;
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (!rst_n_i) begin
         ptr_q  <= '0;
         lock_q <= 1'b0;
      end else begin
         lock_q <= found && !out_if.ready;
         if (accept) begin
            ptr_q <= (sel == ID_W'(NB_CH - 1)) ? '0 : sel + 1'b1;
         end
      end
   end

   always_ff @(posedge sys_clk_i) begin
      lock_id_q <= sel;
   end

endmodule

`default_nettype wire

//--- hdl/hyper_fifo.sv
// Synchronous FIFO with a type-parameter payload
// Circular buffer, read/write pointers and occupancy count

`default_nettype none

module hyper_fifo #(
   parameter int  DEPTH     = 8,
   parameter type payload_t = logic
) (
   input  logic     sys_clk_i,
   input  logic     rst_n_i,
   input  logic     push_valid_i,
   input  payload_t push_data_i,
   output logic     push_ready_o,
   output logic     pop_valid_o,
   output payload_t pop_data_o,
   input  logic     pop_ready_i
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   payload_t        mem [DEPTH];
   logic [AW-1:0]   wr_ptr_q;
   logic [AW-1:0]   rd_ptr_q;
   logic [AW:0]     count_q;
   logic            push;
   logic            pop;

   assign push_ready_o = (count_q != (AW+1)'(DEPTH));
   assign pop_valid_o  = (count_q != '0);
   assign pop_data_o   = mem[rd_ptr_q];

   assign push = push_valid_i && push_ready_o;
   assign pop  = pop_valid_o && pop_ready_i;

   always_ff @(posedge sys_clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         // Simultaneous push and pop leaves the count
         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (push) begin
         mem[wr_ptr_q] <= push_data_i;
      end
   end

endmodule

`default_nettype wire

//--- hdl/hyper_ctrl.sv
// Transaction controller
// Header phase towards the PHY, then write or read word phase
// Word counting and end-of-transfer event per channel

`default_nettype none

module hyper_ctrl #(
   parameter int NB_CH = 4
) (
   input  logic                   sys_clk_i,
   input  logic                   rst_n_i,
   hyper_trans_if.dst             in_if,

   output logic                   trans_valid_o,
   output hyper_pkg::hyper_addr_t trans_addr_o,
   output hyper_pkg::burst_t      trans_burst_o,
   output logic                   trans_write_o,
   input  logic                   trans_ready_i,

   input  hyper_pkg::data_t       tx_word_i,
   input  logic                   tx_word_valid_i,
   output logic                   tx_word_ready_o,
   output hyper_pkg::data_t       tx_data_o,
   output logic                   tx_valid_o,
   output logic                   tx_last_o,
   input  logic                   tx_ready_i,

   input  hyper_pkg::data_t       rx_data_i,
   input  logic                   rx_valid_i,
   output logic                   rx_ready_o,
   output hyper_pkg::data_t       rx_word_o,
   output logic                   rx_word_valid_o,
   input  logic                   rx_word_ready_i,

   output logic [NB_CH-1:0]       evt_eot_o
);
   import hyper_pkg::*;

   localparam int ID_W = (NB_CH > 1) ? $clog2(NB_CH) : 1;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_HEADER,
      ST_WRITE,
      ST_READ,
      ST_DONE
   } state_t;

   state_t          state_q;
   hyper_trans_t    trans_q;
   logic [ID_W-1:0] id_q;
   burst_t          cnt_q;
   logic            tx_beat;
   logic            rx_beat;
   logic            last_word;

   // Pop on entry to the header phase
   assign in_if.ready = (state_q == ST_IDLE);

   assign trans_valid_o = (state_q == ST_HEADER);
   assign trans_addr_o  = trans_q.address;
   assign trans_burst_o = trans_q.burst;
   assign trans_write_o = !trans_q.read;

   ////////////////////////////////////////////////////
   // Data paths
   assign last_word       = (cnt_q == burst_t'(1));

   assign tx_data_o       = tx_word_i;
   assign tx_valid_o      = (state_q == ST_WRITE) && tx_word_valid_i;
   assign tx_word_ready_o = (state_q == ST_WRITE) && tx_ready_i;
   assign tx_last_o       = tx_valid_o && last_word;
   assign tx_beat         = tx_valid_o && tx_ready_i;

   assign rx_word_o       = rx_data_i;
   assign rx_word_valid_o = (state_q == ST_READ) && rx_valid_i;
   assign rx_ready_o      = (state_q == ST_READ) && rx_word_ready_i;
   assign rx_beat         = rx_valid_i && rx_ready_o;

   always_comb begin
      evt_eot_o = '0;
      if (state_q == ST_DONE) begin
         evt_eot_o[id_q] = 1'b1;
      end
   end

   ////////////////////////////////////////////////////
   // FSM
   always_ff @(posedge sys_clk_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (in_if.valid) begin
                  state_q <= ST_HEADER;
               end
            end
            ST_HEADER: begin
               if (trans_ready_i) begin
                  cnt_q <= trans_q.burst;
                  if (trans_q.burst == '0) begin
                     state_q <= ST_DONE;
                  end else begin
                     state_q <= trans_q.read ? ST_READ : ST_WRITE;
                  end
               end
            end
            ST_WRITE, ST_READ: begin
               if (tx_beat || rx_beat) begin
                  cnt_q <= cnt_q - 1'b1;
                  if (last_word) begin
                     state_q <= ST_DONE;
                  end
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Transaction held for the whole run
   always_ff @(posedge sys_clk_i) begin
      if (in_if.valid && in_if.ready) begin
         trans_q <= in_if.trans;
         id_q    <= in_if.id;
      end
   end

endmodule

`default_nettype wire

//--- hdl/udma_hyperbus.sv
// HyperBus front end top level
// Channel command registers and round-robin arbiter
// Transaction FIFO and controller towards the PHY
// TX and RX word FIFOs between uDMA streams and PHY

`default_nettype none

module udma_hyperbus #(
   parameter int NB_CH      = 4,
   parameter int FIFO_DEPTH = 8
) (
   input  logic                             sys_clk_i,
   input  logic                             rst_n_i,

   input  hyper_pkg::data_t                 cfg_data_i,
   input  logic [hyper_pkg::CFG_AWIDTH-1:0] cfg_addr_i,
   input  logic                             cfg_rwn_i,
   input  logic [NB_CH-1:0]                 cfg_valid_i,
   output hyper_pkg::data_t [NB_CH-1:0]     cfg_data_o,
   output logic [NB_CH-1:0]                 cfg_ready_o,

   output logic                             trans_valid_o,
   input  logic                             trans_ready_i,
   output hyper_pkg::hyper_addr_t           trans_addr_o,
   output hyper_pkg::burst_t                trans_burst_o,
   output logic                             trans_write_o,

   input  hyper_pkg::data_t                 data_tx_i,
   input  logic                             data_tx_valid_i,
   output logic                             data_tx_ready_o,
   output hyper_pkg::data_t                 tx_data_o,
   output logic                             tx_valid_o,
   input  logic                             tx_ready_i,
   output logic                             tx_last_o,

   input  hyper_pkg::data_t                 rx_data_i,
   input  logic                             rx_valid_i,
   output logic                             rx_ready_o,
   output hyper_pkg::data_t                 rx_data_udma_o,
   output logic                             rx_valid_udma_o,
   input  logic                             rx_ready_udma_i,

   output logic [NB_CH-1:0]                 evt_eot_o
);
   import hyper_pkg::*;

   localparam int ID_W = (NB_CH > 1) ? $clog2(NB_CH) : 1;

   typedef struct packed {
      hyper_trans_t    trans;
      logic [ID_W-1:0] id;
   } queued_t;

   logic [NB_CH-1:0]         cmd_valid;
   logic [NB_CH-1:0]         cmd_ready;
   hyper_trans_t [NB_CH-1:0] cmd;
   queued_t                  q_pop;

   data_t tx_word;
   logic  tx_word_valid;
   logic  tx_word_ready;
   data_t rx_word;
   logic  rx_word_valid;
   logic  rx_word_ready;

   hyper_trans_if #(.NB_CH(NB_CH)) arb_if ();
   hyper_trans_if #(.NB_CH(NB_CH)) ctrl_if ();

   ////////////////////////////////////////////////////
   // Control path
   for (genvar ch = 0; ch < NB_CH; ch++) begin : g_ch
      hyper_cmd_queue u_cmd_queue (
         .sys_clk_i   ( sys_clk_i      ),
         .rst_n_i     ( rst_n_i        ),
         .cfg_data_i  ( cfg_data_i     ),
         .cfg_addr_i  ( cfg_addr_i     ),
         .cfg_valid_i ( cfg_valid_i[ch] ),
         .cfg_rwn_i   ( cfg_rwn_i      ),
         .cfg_data_o  ( cfg_data_o[ch] ),
         .cfg_ready_o ( cfg_ready_o[ch] ),
         .cmd_valid_o ( cmd_valid[ch]  ),
         .cmd_o       ( cmd[ch]        ),
         .cmd_ready_i ( cmd_ready[ch]  )
      );
   end

   hyper_rr_arb #(.NB_CH(NB_CH)) u_arb (
      .sys_clk_i ( sys_clk_i ),
      .rst_n_i   ( rst_n_i   ),
      .req_i     ( cmd_valid ),
      .cmd_i     ( cmd       ),
      .gnt_o     ( cmd_ready ),
      .out_if    ( arb_if    )
   );

   hyper_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(queued_t)) u_trans_fifo (
      .sys_clk_i    ( sys_clk_i                   ),
      .rst_n_i      ( rst_n_i                     ),
      .push_valid_i ( arb_if.valid                ),
      .push_data_i  ( {arb_if.trans, arb_if.id}   ),
      .push_ready_o ( arb_if.ready                ),
      .pop_valid_o  ( ctrl_if.valid               ),
      .pop_data_o   ( q_pop                       ),
      .pop_ready_i  ( ctrl_if.ready               )
   );

   assign ctrl_if.trans = q_pop.trans;
   assign ctrl_if.id    = q_pop.id;

   hyper_ctrl #(.NB_CH(NB_CH)) u_ctrl (
      .sys_clk_i       ( sys_clk_i     ),
      .rst_n_i         ( rst_n_i       ),
      .in_if           ( ctrl_if       ),
      .trans_valid_o   ( trans_valid_o ),
      .trans_addr_o    ( trans_addr_o  ),
      .trans_burst_o   ( trans_burst_o ),
      .trans_write_o   ( trans_write_o ),
      .trans_ready_i   ( trans_ready_i ),
      .tx_word_i       ( tx_word       ),
      .tx_word_valid_i ( tx_word_valid ),
      .tx_word_ready_o ( tx_word_ready ),
      .tx_data_o       ( tx_data_o     ),
      .tx_valid_o      ( tx_valid_o    ),
      .tx_last_o       ( tx_last_o     ),
      .tx_ready_i      ( tx_ready_i    ),
      .rx_data_i       ( rx_data_i     ),
      .rx_valid_i      ( rx_valid_i    ),
      .rx_ready_o      ( rx_ready_o    ),
      .rx_word_o       ( rx_word       ),
      .rx_word_valid_o ( rx_word_valid ),
      .rx_word_ready_i ( rx_word_ready ),
      .evt_eot_o       ( evt_eot_o     )
   );

   ////////////////////////////////////////////////////
   // Data path
   hyper_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(data_t)) u_tx_fifo (
      .sys_clk_i    ( sys_clk_i       ),
      .rst_n_i      ( rst_n_i         ),
      .push_valid_i ( data_tx_valid_i ),
      .push_data_i  ( data_tx_i       ),
      .push_ready_o ( data_tx_ready_o ),
      .pop_valid_o  ( tx_word_valid   ),
      .pop_data_o   ( tx_word         ),
      .pop_ready_i  ( tx_word_ready   )
   );

   hyper_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(data_t)) u_rx_fifo (
      .sys_clk_i    ( sys_clk_i       ),
      .rst_n_i      ( rst_n_i         ),
      .push_valid_i ( rx_word_valid   ),
      .push_data_i  ( rx_word         ),
      .push_ready_o ( rx_word_ready   ),
      .pop_valid_o  ( rx_valid_udma_o ),
      .pop_data_o   ( rx_data_udma_o  ),
      .pop_ready_i  ( rx_ready_udma_i )
   );

endmodule

`default_nettype wire

//--- testbench/udma_hyperbus_props.sv
// Concurrent assertions on the front end ports
// Header stability, tx_last_o framing, one-hot end-of-transfer

`default_nettype none

module udma_hyperbus_props #(
   parameter int NB_CH = 4
) (
   input logic                   sys_clk_i,
   input logic                   rst_n_i,
   input logic                   trans_valid_o,
   input logic                   trans_ready_i,
   input hyper_pkg::hyper_addr_t trans_addr_o,
   input hyper_pkg::burst_t      trans_burst_o,
   input logic                   trans_write_o,
   input logic                   tx_valid_o,
   input logic                   tx_last_o,
   input logic [NB_CH-1:0]       evt_eot_o
);

   int unsigned fail_cnt = 0;

   // Header held until the PHY accepts it
   a_hdr_stable: assert property (
      @(posedge sys_clk_i) disable iff (!rst_n_i)
      trans_valid_o && !trans_ready_i |=> trans_valid_o && $stable(trans_addr_o)
         && $stable(trans_burst_o) && $stable(trans_write_o)
   ) else begin
      fail_cnt++;
      $error("transaction header changed before trans_ready_i");
   end

   a_last_valid: assert property (
      @(posedge sys_clk_i) disable iff (!rst_n_i)
      tx_last_o |-> tx_valid_o
   ) else begin
      fail_cnt++;
      $error("tx_last_o high without tx_valid_o");
   end

   a_eot_onehot: assert property (
      @(posedge sys_clk_i) disable iff (!rst_n_i)
      $onehot0(evt_eot_o)
   ) else begin
      fail_cnt++;
      $error("evt_eot_o is not one-hot");
   end

endmodule

`default_nettype wire

//--- testbench/tb_udma_hyperbus.sv
// Testbench for the HyperBus front end
// Command table applied in a loop over the configuration bus
// PHY and uDMA stream models with LFSR-driven stalls
// Header, data, status and end-of-transfer checks

`default_nettype none

module tb_udma_hyperbus;
   import hyper_pkg::*;

   localparam int NB_CH   = 4;
   localparam int N_ROWS  = 6;
   localparam int TIMEOUT = 500;

   typedef struct packed {
      logic [1:0]  ch;
      hyper_addr_t addr;
      burst_t      burst;
      logic        rw;
   } row_t;

   typedef struct packed {
      hyper_addr_t addr;
      burst_t      burst;
      logic        write;
   } hdr_t;

   logic                  clk;
   logic                  rst_n;
   data_t                 cfg_data_i;
   logic [CFG_AWIDTH-1:0] cfg_addr_i;
   logic                  cfg_rwn_i;
   logic [NB_CH-1:0]      cfg_valid_i;
   data_t [NB_CH-1:0]     cfg_data_o;
   logic [NB_CH-1:0]      cfg_ready_o;
   logic                  trans_valid_o;
   logic                  trans_ready_i;
   hyper_addr_t           trans_addr_o;
   burst_t                trans_burst_o;
   logic                  trans_write_o;
   data_t                 data_tx_i;
   logic                  data_tx_valid_i;
   logic                  data_tx_ready_o;
   data_t                 tx_data_o;
   logic                  tx_valid_o;
   logic                  tx_ready_i;
   logic                  tx_last_o;
   data_t                 rx_data_i;
   logic                  rx_valid_i;
   logic                  rx_ready_o;
   data_t                 rx_data_udma_o;
   logic                  rx_valid_udma_o;
   logic                  rx_ready_udma_i;
   logic [NB_CH-1:0]      evt_eot_o;

   row_t        rows [N_ROWS];
   logic [15:0] lfsr_q;
   int          err_cnt;
   int          chk_cnt;
   logic        timed_out;
   data_t       feed_q [$];
   data_t       tx_exp_q [$];
   data_t       rx_exp_q [$];
   hdr_t        hdr_q [$];
   int          eot_q [$];
   hyper_addr_t rx_base;
   int          rx_idx;
   int          rx_left;

   udma_hyperbus #(.NB_CH(NB_CH), .FIFO_DEPTH(8)) DUT (
      .sys_clk_i ( clk   ),
      .rst_n_i   ( rst_n ),
      .*
   );

   bind udma_hyperbus udma_hyperbus_props #(.NB_CH(NB_CH)) u_props (
      .sys_clk_i     ( sys_clk_i     ),
      .rst_n_i       ( rst_n_i       ),
      .trans_valid_o ( trans_valid_o ),
      .trans_ready_i ( trans_ready_i ),
      .trans_addr_o  ( trans_addr_o  ),
      .trans_burst_o ( trans_burst_o ),
      .trans_write_o ( trans_write_o ),
      .tx_valid_o    ( tx_valid_o    ),
      .tx_last_o     ( tx_last_o     ),
      .evt_eot_o     ( evt_eot_o     )
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   ////////////////////////////////////////////////////
   // Helpers

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = s >> 1;
      if (s[0]) begin
         lfsr_next = lfsr_next ^ 16'hB400;
      end
   endfunction

   task automatic draw_bit(output logic b);
      b      = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      chk_cnt++;
      assert (got === exp) else begin
         err_cnt++;
         $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_true(input logic cond, input string msg);
      chk_cnt++;
      assert (cond) else begin
         err_cnt++;
         $display("%s", msg);
      end
   endtask

   function automatic hyper_addr_t rr_addr(input int ch);
      rr_addr = 32'hA000_0000 + hyper_addr_t'(ch * 256);
   endfunction

   task automatic cfg_write(input int ch, input logic [CFG_AWIDTH-1:0] addr, input data_t data);
      cfg_valid_i     = '0;
      cfg_valid_i[ch] = 1'b1;
      cfg_addr_i      = addr;
      cfg_data_i      = data;
      cfg_rwn_i       = 1'b0;
      @(negedge clk);
      check_val("cfg_ready_o", 32'(cfg_ready_o[ch]), 32'd1);
      @(posedge clk);
      #1;
      cfg_valid_i = '0;
      cfg_rwn_i   = 1'b1;
   endtask

   task automatic wait_status_clear(input int ch);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         #1;
         n++;
      end while (cfg_data_o[ch][0] !== 1'b0 && n < TIMEOUT);
      if (cfg_data_o[ch][0] !== 1'b0) begin
         timed_out = 1'b1;
         $display("timeout waiting for the channel %0d command to be granted", ch);
      end
   endtask

   task automatic wait_eot(input int cnt);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         #1;
         n++;
      end while (eot_q.size() < cnt && n < TIMEOUT);
      if (eot_q.size() < cnt) begin
         timed_out = 1'b1;
         $display("timeout waiting for end-of-transfer events");
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      do begin
         @(posedge clk);
         #1;
         n++;
      end while ((feed_q.size() + tx_exp_q.size() + rx_exp_q.size()) != 0 && n < TIMEOUT);
      if ((feed_q.size() + tx_exp_q.size() + rx_exp_q.size()) != 0) begin
         timed_out = 1'b1;
         $display("timeout waiting for the data words of a transaction");
      end
   endtask

   ////////////////////////////////////////////////////
   // Table row and round-robin sequences

   task automatic run_row(input int i);
      row_t r;
      hdr_t h;
      r = rows[i];
      cfg_write(r.ch, REG_ADDR, r.addr);
      cfg_write(r.ch, REG_SIZE, data_t'(r.burst));
      cfg_write(r.ch, REG_CTRL, data_t'(r.rw));
      cfg_addr_i = REG_STATUS;
      @(negedge clk);
      check_val("cfg_data_o", cfg_data_o[r.ch], 32'd1);
      for (int k = 0; k < int'(r.burst); k++) begin
         if (r.rw) begin
            rx_exp_q.push_back(~r.addr + data_t'(k));
         end else begin
            feed_q.push_back(r.addr + data_t'(k));
            tx_exp_q.push_back(r.addr + data_t'(k));
         end
      end
      wait_status_clear(r.ch);
      if (!timed_out) begin
         wait_eot(1);
      end
      if (timed_out) begin
         return;
      end
      check_true(hdr_q.size() == 1, "missing or extra transaction header");
      h = hdr_q.pop_front();
      check_val("trans_addr_o", h.addr, r.addr);
      check_val("trans_burst_o", 32'(h.burst), 32'(r.burst));
      check_val("trans_write_o", 32'(h.write), 32'(!r.rw));
      check_val("evt_eot_o channel", eot_q.pop_front(), r.ch);
      wait_drained();
      check_true(eot_q.size() == 0, "extra end-of-transfer pulse after a transaction");
   endtask

   task automatic run_round_robin(input int first);
      int   ch;
      hdr_t h;
      for (int c = 0; c < NB_CH; c++) begin
         cfg_write(c, REG_ADDR, rr_addr(c));
         cfg_write(c, REG_SIZE, data_t'(c + 2));
      end
      // All four commands land on the same edge
      cfg_valid_i = '1;
      cfg_addr_i  = REG_CTRL;
      cfg_data_i  = 32'd1;
      cfg_rwn_i   = 1'b0;
      @(posedge clk);
      #1;
      cfg_valid_i = '0;
      cfg_rwn_i   = 1'b1;
      cfg_addr_i  = REG_STATUS;
      @(negedge clk);
      for (int k = 0; k < NB_CH; k++) begin
         ch = (first + k) % NB_CH;
         check_val("cfg_data_o", cfg_data_o[ch], 32'd1);
         for (int w = 0; w < ch + 2; w++) begin
            rx_exp_q.push_back(~rr_addr(ch) + data_t'(w));
         end
      end
      wait_eot(NB_CH);
      if (timed_out) begin
         return;
      end
      check_true(hdr_q.size() == NB_CH, "wrong number of transaction headers");
      for (int k = 0; k < NB_CH; k++) begin
         ch = (first + k) % NB_CH;
         h  = hdr_q.pop_front();
         check_val("trans_addr_o", h.addr, rr_addr(ch));
         check_val("trans_burst_o", 32'(h.burst), 32'(ch + 2));
         check_val("evt_eot_o channel", eot_q.pop_front(), ch);
      end
      wait_drained();
   endtask

   ////////////////////////////////////////////////////
   // PHY and uDMA models, driven after the edge

   always @(posedge clk) begin : drive_models
      logic b;
      #1;
      draw_bit(b);
      trans_ready_i = trans_valid_o && b;
      draw_bit(b);
      tx_ready_i = b;
      draw_bit(b);
      rx_ready_udma_i = b;
      data_tx_valid_i = (feed_q.size() != 0);
      data_tx_i       = (feed_q.size() != 0) ? feed_q[0] : '0;
      rx_valid_i      = (rx_left != 0);
      rx_data_i       = ~rx_base + data_t'(rx_idx);
   end

   // Handshakes sampled mid-cycle
   always @(negedge clk) begin : monitor
      hdr_t h;
      if (rst_n) begin
         if (data_tx_valid_i && data_tx_ready_o) begin
            void'(feed_q.pop_front());
         end
         if (trans_valid_o && trans_ready_i) begin
            h.addr  = trans_addr_o;
            h.burst = trans_burst_o;
            h.write = trans_write_o;
            hdr_q.push_back(h);
            if (!h.write) begin
               rx_base = h.addr;
               rx_idx  = 0;
               rx_left = int'(h.burst);
            end
         end
         if (tx_valid_o && tx_ready_i) begin
            check_true(tx_exp_q.size() != 0, "write word beyond the burst length");
            if (tx_exp_q.size() != 0) begin
               check_val("tx_last_o", 32'(tx_last_o), 32'(tx_exp_q.size() == 1));
               check_val("tx_data_o", tx_data_o, tx_exp_q.pop_front());
            end
         end
         if (rx_valid_i && rx_ready_o) begin
            rx_idx++;
            rx_left--;
         end
         if (rx_valid_udma_o && rx_ready_udma_i) begin
            check_true(rx_exp_q.size() != 0, "read word beyond the burst length");
            if (rx_exp_q.size() != 0) begin
               check_val("rx_data_udma_o", rx_data_udma_o, rx_exp_q.pop_front());
            end
         end
         if (evt_eot_o != '0) begin
            check_true($onehot(evt_eot_o), "several end-of-transfer events in one cycle");
            for (int c = 0; c < NB_CH; c++) begin
               if (evt_eot_o[c]) begin
                  eot_q.push_back(c);
               end
            end
         end
      end
   end

   ////////////////////////////////////////////////////
   // Main sequence

   initial begin : main
      lfsr_q          = 16'd60954;
      err_cnt         = 0;
      chk_cnt         = 0;
      timed_out       = 1'b0;
      rx_base         = '0;
      rx_idx          = 0;
      rx_left         = 0;
      rst_n           = 1'b0;
      cfg_data_i      = '0;
      cfg_addr_i      = '0;
      cfg_rwn_i       = 1'b1;
      cfg_valid_i     = '0;
      trans_ready_i   = 1'b0;
      data_tx_i       = '0;
      data_tx_valid_i = 1'b0;
      tx_ready_i      = 1'b0;
      rx_data_i       = '0;
      rx_valid_i      = 1'b0;
      rx_ready_udma_i = 1'b0;

      rows[0] = '{2'd0, 32'h1000_0000, 16'd5, 1'b0};
      rows[1] = '{2'd1, 32'h2000_0040, 16'd3, 1'b1};
      rows[2] = '{2'd3, 32'h0000_1234, 16'd12, 1'b0};
      rows[3] = '{2'd2, 32'h8000_0100, 16'd10, 1'b1};
      rows[4] = '{2'd1, 32'hCAFE_0000, 16'd1, 1'b0};
      rows[5] = '{2'd0, 32'h0F0F_0F00, 16'd2, 1'b1};

      repeat (10) @(posedge clk);
      #1;
      check_val("trans_valid_o", 32'(trans_valid_o), 32'd0);
      check_val("tx_valid_o", 32'(tx_valid_o), 32'd0);
      check_val("tx_last_o", 32'(tx_last_o), 32'd0);
      check_val("rx_ready_o", 32'(rx_ready_o), 32'd0);
      check_val("rx_valid_udma_o", 32'(rx_valid_udma_o), 32'd0);
      check_val("evt_eot_o", 32'(evt_eot_o), 32'd0);
      check_val("data_tx_ready_o", 32'(data_tx_ready_o), 32'd1);
      rst_n = 1'b1;

      for (int i = 0; i < N_ROWS; i++) begin
         if (!timed_out) begin
            run_row(i);
         end
      end
      if (!timed_out) begin
         run_round_robin((int'(rows[N_ROWS-1].ch) + 1) % NB_CH);
      end

      err_cnt = err_cnt + int'(DUT.u_props.fail_cnt);
      $display("checks: %0d, errors: %0d, timeouts: %0d", chk_cnt, err_cnt, timed_out);
      if (err_cnt == 0 && !timed_out) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
hdl/hyper_pkg.sv
hdl/hyper_trans_if.sv
hdl/hyper_cmd_queue.sv
hdl/hyper_rr_arb.sv
hdl/hyper_fifo.sv
hdl/hyper_ctrl.sv
hdl/udma_hyperbus.sv
testbench/udma_hyperbus_props.sv
testbench/tb_udma_hyperbus.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_udma_hyperbus
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
